/* tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

    // Table geometry
    localparam int tlb_entries = 16;
    localparam int index_w     = 4;

    typedef logic [index_w-1:0] index_t;

    // Address fields, 4 KB pages and 32-bit physical space
    typedef logic [19:0] vpn_t;        // VA[31:12]
    typedef logic [18:0] vpn2_t;       // VA[31:13], one tag covers an even/odd pair
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;        // PA[31:12]
    typedef logic [2:0]  cache_attr_t;

    // Cache attribute forced in kseg1
    localparam cache_attr_t uncached_attr = 3'd2;

    // Maintenance commands
    typedef enum logic [1:0] {
        cmd_none  = 2'd0,
        cmd_read  = 2'd1,              // tlbr
        cmd_write = 2'd2               // tlbwi
    } tlb_cmd_e;

    // Tag half of an entry, as in EntryHi
    typedef struct packed {
        vpn2_t vpn2;
        asid_t asid;
        logic  g;
    } entry_hi_t;

    // One page descriptor, as in EntryLo
    typedef struct packed {
        pfn_t        pfn;
        cache_attr_t c;
        logic        d;
        logic        v;
    } entry_lo_t;

    // RAM word, even page in the upper half
    typedef struct packed {
        entry_lo_t lo0;
        entry_lo_t lo1;
    } page_pair_t;

    typedef struct packed {
        vpn_t  vpn;
        asid_t asid;
    } lookup_req_t;

    // Segment decode carried with a lookup through the pipeline
    typedef struct packed {
        logic unmapped;                // kseg0 or kseg1
        logic uncached;                // kseg1
        logic use_kseg0;               // kseg0 attribute from config input
        pfn_t unmapped_pfn;            // Direct-mapped frame
    } seg_info_t;

    // First-stage register of each lookup port
    typedef struct packed {
        logic      hit;
        logic      odd_page;
        index_t    index;
        seg_info_t seg;
    } match_t;

    typedef struct packed {
        logic        hit;
        pfn_t        pfn;
        cache_attr_t cache;
        logic        dirty;
        logic        valid;
    } translation_t;

endpackage

`default_nettype wire

/* tlb_tag_cam.sv */
`timescale 1ns/100ps
`default_nettype none

module tlb_tag_cam (
    input  logic                clock,
    input  logic                rst,
    input  logic                write,
    input  tlb_pkg::index_t     index,
    input  tlb_pkg::entry_hi_t  entry_hi_in,
    output tlb_pkg::entry_hi_t  entry_hi_rd,
    input  tlb_pkg::lookup_req_t i_req,
    input  tlb_pkg::lookup_req_t d_req,
    output logic                i_hit,
    output logic                d_hit,
    output tlb_pkg::index_t     i_index,
    output tlb_pkg::index_t     d_index
);

    import tlb_pkg::*;

    entry_hi_t tags [tlb_entries];

    // Search all tags for one request, upper entries override lower ones
    function automatic logic [index_w:0] find_match(input lookup_req_t req);
        logic   hit;
        index_t idx;
        hit = 1'b0;
        idx = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            if ((tags[i].vpn2 == req.vpn[19:1]) &&
                ((tags[i].asid == req.asid) || tags[i].g)) begin
                hit = 1'b1;
                idx = index_t'(i);
            end
        end
        return {hit, idx};
    endfunction

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < tlb_entries; i++) begin
                tags[i] <= '0;
            end
        end else if (write) begin
            tags[index] <= entry_hi_in;             // tlbwi
        end
    end

    assign entry_hi_rd = tags[index];                // tlbr source

    always_comb begin
        {i_hit, i_index} = find_match(i_req);
        {d_hit, d_index} = find_match(d_req);
    end

    // A write to an unknown slot would corrupt the whole table
    a_write_index_known: assert property (
        @(posedge clock) disable iff (rst)
        write |-> !$isunknown(index)
    ) else $error("tlb_tag_cam write with unknown index");

endmodule

`default_nettype wire

/* tlb_page_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module tlb_page_ram (
    input  logic                 clock,
    input  logic                 rst,
    input  tlb_pkg::index_t      addr_a,
    input  logic                 we_a,
    input  tlb_pkg::page_pair_t  din_a,
    output tlb_pkg::page_pair_t  dout_a,
    input  tlb_pkg::index_t      addr_b,
    output tlb_pkg::page_pair_t  dout_b
);

    import tlb_pkg::*;

    page_pair_t mem [tlb_entries];

    // Port A, shared by tlbwi/tlbr and data lookups
    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < tlb_entries; i++) begin
                mem[i] <= '0;
            end
            dout_a <= '0;
        end else begin
            if (we_a) begin
                mem[addr_a] <= din_a;
            end
            dout_a <= mem[addr_a];                   // Old data on a write cycle
        end
    end

    // Port B, instruction lookups only
    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            dout_b <= '0;
        end else begin
            dout_b <= mem[addr_b];
        end
    end

endmodule

`default_nettype wire

/* tlb_match_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tlb_match_stage (
    input  logic                  clock,
    input  logic                  rst,
    input  tlb_pkg::lookup_req_t  req,
    input  logic                  cam_hit,
    input  tlb_pkg::index_t       cam_index,
    output tlb_pkg::match_t       match
);

    import tlb_pkg::*;

    seg_info_t seg;
    match_t    match_next;

    // Segment decode on VA[31:29]
    always_comb begin
        seg.unmapped     = (req.vpn[19:18] == 2'b10);     // kseg0/kseg1
        seg.uncached     = (req.vpn[19:17] == 3'b101);    // kseg1
        seg.use_kseg0    = (req.vpn[19:17] == 3'b100);    // kseg0
        seg.unmapped_pfn = {3'b000, req.vpn[16:0]};       // Strip segment bits
    end

    always_comb begin
        match_next.hit      = cam_hit;
        match_next.odd_page = req.vpn[0];                 // VA[12] picks lo1
        match_next.index    = cam_index;
        match_next.seg      = seg;
    end

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            match <= '0;
        end else begin
            match <= match_next;
        end
    end

endmodule

`default_nettype wire

/* tlb_result_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tlb_result_stage (
    input  tlb_pkg::match_t       match,
    input  tlb_pkg::page_pair_t   page_pair,
    input  tlb_pkg::cache_attr_t  kseg0_cache,
    output tlb_pkg::translation_t trans
);

    import tlb_pkg::*;

    entry_lo_t lo;

    // Even/odd descriptor of the pair
    assign lo = match.odd_page ? page_pair.lo1 : page_pair.lo0;

    always_comb begin
        if (match.seg.unmapped) begin
            // Direct-mapped segments always translate
            trans.hit   = 1'b1;
            trans.pfn   = match.seg.unmapped_pfn;
            trans.dirty = 1'b1;
            trans.valid = 1'b1;
        end else begin
            trans.hit   = match.hit;
            trans.pfn   = lo.pfn;
            trans.dirty = lo.d;
            trans.valid = lo.v;
        end

        if (match.seg.uncached) begin
            trans.cache = uncached_attr;             // kseg1
        end else if (match.seg.use_kseg0) begin
            trans.cache = kseg0_cache;               // Config0.K0 level
        end else begin
            trans.cache = lo.c;
        end
    end

endmodule

`default_nettype wire

/* tlb_16.sv */
`timescale 1ns/100ps
`default_nettype none

module tlb_16 (
    input  logic                   clock,
    input  logic                   rst,
    // Lookup ports
    input  tlb_pkg::lookup_req_t   i_req,
    input  tlb_pkg::lookup_req_t   d_req,
    output tlb_pkg::translation_t  i_trans,
    output tlb_pkg::translation_t  d_trans,
    // Maintenance
    input  tlb_pkg::tlb_cmd_e      cmd,
    input  tlb_pkg::index_t        index,
    input  tlb_pkg::entry_hi_t     entry_hi_in,
    input  tlb_pkg::page_pair_t    lo_pair_in,
    output tlb_pkg::index_t        probe_index,
    output tlb_pkg::entry_hi_t     entry_hi_out,
    output tlb_pkg::page_pair_t    lo_pair_out,
    // Static configuration
    input  tlb_pkg::cache_attr_t   kseg0_cache
);

    import tlb_pkg::*;

    logic       cam_write;
    entry_hi_t  entry_hi_rd;
    logic       i_cam_hit;
    logic       d_cam_hit;
    index_t     i_cam_index;
    index_t     d_cam_index;

    match_t     i_match;
    match_t     d_match;

    index_t     ram_addr_a;
    logic       ram_we_a;
    page_pair_t ram_dout_a;
    page_pair_t ram_dout_b;

    // Command decode
    assign cam_write  = (cmd == cmd_write);
    assign ram_we_a   = (cmd == cmd_write);
    assign ram_addr_a = ((cmd == cmd_read) || (cmd == cmd_write)) ? index : d_cam_index;

    tlb_tag_cam u_cam (
        .clock       (clock),
        .rst         (rst),
        .write       (cam_write),
        .index       (index),
        .entry_hi_in (entry_hi_in),
        .entry_hi_rd (entry_hi_rd),
        .i_req       (i_req),
        .d_req       (d_req),
        .i_hit       (i_cam_hit),
        .d_hit       (d_cam_hit),
        .i_index     (i_cam_index),
        .d_index     (d_cam_index)
    );

    tlb_page_ram u_ram (
        .clock  (clock),
        .rst    (rst),
        .addr_a (ram_addr_a),
        .we_a   (ram_we_a),
        .din_a  (lo_pair_in),
        .dout_a (ram_dout_a),
        .addr_b (i_cam_index),
        .dout_b (ram_dout_b)
    );

    // Instruction port pipeline
    tlb_match_stage u_i_match (
        .clock     (clock),
        .rst       (rst),
        .req       (i_req),
        .cam_hit   (i_cam_hit),
        .cam_index (i_cam_index),
        .match     (i_match)
    );

    tlb_result_stage u_i_result (
        .match       (i_match),
        .page_pair   (ram_dout_b),
        .kseg0_cache (kseg0_cache),
        .trans       (i_trans)
    );

    // Data port pipeline, also serves tlbp
    tlb_match_stage u_d_match (
        .clock     (clock),
        .rst       (rst),
        .req       (d_req),
        .cam_hit   (d_cam_hit),
        .cam_index (d_cam_index),
        .match     (d_match)
    );

    tlb_result_stage u_d_result (
        .match       (d_match),
        .page_pair   (ram_dout_a),
        .kseg0_cache (kseg0_cache),
        .trans       (d_trans)
    );

    // Tag read lines up with the RAM word on port A
    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            entry_hi_out <= '0;
        end else begin
            entry_hi_out <= entry_hi_rd;
        end
    end

    assign lo_pair_out = ram_dout_a;
    assign probe_index = d_match.index;              // Same cycle as d_trans

    a_cmd_legal: assert property (
        @(posedge clock) disable iff (rst)
        cmd inside {cmd_none, cmd_read, cmd_write}
    ) else $error("tlb_16 illegal command encoding");

endmodule

`default_nettype wire

/* tb_tlb_16.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_tlb_16;

    import tlb_pkg::*;

    logic         clock;
    logic         rst;
    lookup_req_t  i_req;
    lookup_req_t  d_req;
    tlb_cmd_e     cmd;
    index_t       index;
    entry_hi_t    entry_hi_in;
    page_pair_t   lo_pair_in;
    cache_attr_t  kseg0_cache;
    translation_t i_trans;
    translation_t d_trans;
    index_t       probe_index;
    entry_hi_t    entry_hi_out;
    page_pair_t   lo_pair_out;

    entry_hi_t    model_hi [tlb_entries];    // Reference copy of the table
    page_pair_t   model_lo [tlb_entries];

    int   seed = 32'h29d21521;
    int   check_count = 0;
    int   trans_errors = 0;
    int   read_errors = 0;
    int   probe_errors = 0;
    logic finish_req = 1'b0;
    logic compare_done = 1'b0;

    tlb_16 dut_i (
        .clock(clock), .rst(rst), .i_req(i_req), .d_req(d_req),
        .i_trans(i_trans), .d_trans(d_trans), .cmd(cmd), .index(index),
        .entry_hi_in(entry_hi_in), .lo_pair_in(lo_pair_in), .probe_index(probe_index),
        .entry_hi_out(entry_hi_out), .lo_pair_out(lo_pair_out), .kseg0_cache(kseg0_cache)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic lookup_req_t make_req(input vpn_t vpn, input asid_t asid);
        lookup_req_t req;
        req.vpn  = vpn;
        req.asid = asid;
        return req;
    endfunction

    function automatic entry_hi_t make_hi(input vpn2_t vpn2, input asid_t asid, input logic g);
        entry_hi_t hi;
        hi.vpn2 = vpn2;
        hi.asid = asid;
        hi.g    = g;
        return hi;
    endfunction

    function automatic entry_lo_t make_lo(input pfn_t pfn, input cache_attr_t c,
                                          input logic d, input logic v);
        entry_lo_t lo;
        lo.pfn = pfn;
        lo.c   = c;
        lo.d   = d;
        lo.v   = v;
        return lo;
    endfunction

    function automatic page_pair_t make_pair(input entry_lo_t even, input entry_lo_t odd);
        page_pair_t pp;
        pp.lo0 = even;
        pp.lo1 = odd;
        return pp;
    endfunction

    // Highest matching entry, -1 on a miss
    function automatic int winning_entry(input lookup_req_t req);
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if ((model_hi[i].vpn2 == req.vpn[19:1]) &&
                (model_hi[i].g || (model_hi[i].asid == req.asid))) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic translation_t expect_trans(input lookup_req_t req, input cache_attr_t k0);
        translation_t t;
        entry_lo_t    lo;
        int           win;
        logic [2:0]   seg;
        win = winning_entry(req);
        seg = req.vpn[19:17];
        lo  = '0;
        if (win >= 0) begin
            lo = req.vpn[0] ? model_lo[win].lo1 : model_lo[win].lo0;   // Odd page on VA[12]
        end
        t.hit   = (win >= 0);
        t.pfn   = lo.pfn;
        t.cache = lo.c;
        t.dirty = lo.d;
        t.valid = lo.v;
        if (seg[2:1] == 2'b10) begin
            // kseg0 and kseg1 bypass the table
            t.hit   = 1'b1;
            t.pfn   = {3'b000, req.vpn[16:0]};
            t.dirty = 1'b1;
            t.valid = 1'b1;
            t.cache = (seg == 3'b101) ? uncached_attr : k0;
        end
        return t;
    endfunction

    // Requests biased toward tags that are in the table
    function automatic lookup_req_t random_req();
        logic [31:0] r;
        int          k;
        lookup_req_t req;
        r = $random(seed);
        k = int'(r[11:8]);
        case (r[1:0])
            2'd0: req = make_req({model_hi[k].vpn2, r[2]}, r[3] ? model_hi[k].asid : r[23:16]);
            2'd1: req = make_req({2'b10, r[21:4]}, r[31:24]);             // kseg0/kseg1
            default: req = make_req({r[12] ? 3'b110 : 3'b001, 12'h000, r[3:0], r[13]},
                                    {6'd0, r[5:4]});
        endcase
        return req;
    endfunction

    task automatic check_trans(input string port, input translation_t got,
                               input translation_t exp);
        check_count++;
        if (exp.hit) begin
            assert (got == exp) else begin
                trans_errors++;
                $display("** Error at %0t ns: %s port translation %h, expected %h",
                         $time, port, got, exp);
            end
        end else begin
            assert (!got.hit) else begin                  // Descriptor fields undefined on a miss
                trans_errors++;
                $display("** Error at %0t ns: %s port hit on a lookup that should miss",
                         $time, port);
            end
        end
    endtask

    task automatic check_read(input entry_hi_t exp_hi, input page_pair_t exp_lo);
        check_count++;
        assert ((entry_hi_out == exp_hi) && (lo_pair_out == exp_lo)) else begin
            read_errors++;
            $display("** Error at %0t ns: tlbr returned %h/%h, expected %h/%h",
                     $time, entry_hi_out, lo_pair_out, exp_hi, exp_lo);
        end
    endtask

    task automatic check_probe(input index_t exp);
        check_count++;
        assert (probe_index == exp) else begin
            probe_errors++;
            $display("** Error at %0t ns: probe index %0d, expected %0d",
                     $time, probe_index, exp);
        end
    endtask

    // Expected values are taken one cycle before the outputs show them
    initial begin : compare
        translation_t pend_i;
        translation_t pend_d;
        int           pend_probe;
        tlb_cmd_e     pend_cmd;
        entry_hi_t    pend_hi;
        page_pair_t   pend_lo;
        logic         pend_valid;
        for (int i = 0; i < tlb_entries; i++) begin
            model_hi[i] = '0;
            model_lo[i] = '0;
        end
        pend_valid = 1'b0;
        pend_i = '0;
        pend_d = '0;
        pend_probe = -1;
        pend_cmd = cmd_none;
        pend_hi = '0;
        pend_lo = '0;
        while (!compare_done) begin
            @(negedge clock);
            if (rst) begin
                pend_valid = 1'b0;
            end else begin
                if (pend_valid) begin
                    check_trans("i", i_trans, pend_i);
                    if (pend_cmd == cmd_none) begin
                        check_trans("d", d_trans, pend_d);
                        if (pend_probe >= 0) begin
                            check_probe(index_t'(pend_probe));
                        end
                    end else if (pend_cmd == cmd_read) begin
                        check_read(pend_hi, pend_lo);
                    end
                end
                if (finish_req) begin
                    compare_done = 1'b1;
                end else begin
                    pend_i     = expect_trans(i_req, kseg0_cache);
                    pend_d     = expect_trans(d_req, kseg0_cache);
                    pend_probe = winning_entry(d_req);
                    pend_cmd   = cmd;
                    pend_hi    = model_hi[index];
                    pend_lo    = model_lo[index];
                    if (cmd == cmd_write) begin
                        model_hi[index] = entry_hi_in;          // tlbwi lands at this edge
                        model_lo[index] = lo_pair_in;
                    end
                    pend_valid = 1'b1;
                end
            end
        end
    end

    task automatic apply_cycle(input tlb_cmd_e c, input index_t idx, input entry_hi_t hi,
                               input page_pair_t pp, input lookup_req_t ir,
                               input lookup_req_t dr);
        @(posedge clock);
        cmd         <= c;
        index       <= idx;
        entry_hi_in <= hi;
        lo_pair_in  <= pp;
        i_req       <= ir;
        d_req       <= dr;
    endtask

    task automatic lookup(input lookup_req_t ir, input lookup_req_t dr);
        apply_cycle(cmd_none, '0, '0, '0, ir, dr);
    endtask

    task automatic write_entry(input index_t idx, input entry_hi_t hi, input page_pair_t pp);
        apply_cycle(cmd_write, idx, hi, pp, make_req(20'h00000, 8'h55),
                    make_req(20'h00000, 8'h55));
    endtask

    task automatic read_entry(input index_t idx);
        apply_cycle(cmd_read, idx, '0, '0, make_req(20'h00000, 8'h55),
                    make_req(20'h00000, 8'h55));
    endtask

    initial begin : stimulus
        logic [31:0] r;
        entry_hi_t   hi;
        page_pair_t  pp;
        int          wait_count;
        rst         = 1'b1;
        cmd         = cmd_none;
        index       = '0;
        entry_hi_in = '0;
        lo_pair_in  = '0;
        i_req       = make_req(20'h00000, 8'h55);    // ASID that misses the zeroed tags
        d_req       = make_req(20'h00000, 8'h55);
        kseg0_cache = 3'd3;
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        check_count++;
        assert (!i_trans.hit && !d_trans.hit) else begin
            trans_errors++;
            $display("** Error at %0t ns: hit set right after reset", $time);
        end
        for (int k = 0; k < tlb_entries; k++) begin
            read_entry(index_t'(k));
        end

        write_entry(4'd3, make_hi(19'h00010, 8'h11, 1'b0), make_pair(
            make_lo(20'h0A000, 3'd3, 1'b1, 1'b1), make_lo(20'h0A001, 3'd1, 1'b0, 1'b1)));
        write_entry(4'd5, make_hi(19'h00020, 8'h22, 1'b1), make_pair(
            make_lo(20'h0B000, 3'd0, 1'b1, 1'b0), make_lo(20'h0B001, 3'd3, 1'b1, 1'b1)));
        write_entry(4'd7, make_hi(19'h60004, 8'h11, 1'b0), make_pair(
            make_lo(20'h0C000, 3'd2, 1'b0, 1'b1), make_lo(20'h0C001, 3'd3, 1'b1, 1'b1)));
        write_entry(4'd9, make_hi(19'h00010, 8'h33, 1'b0), make_pair(
            make_lo(20'h0D000, 3'd4, 1'b1, 1'b1), make_lo(20'h0D001, 3'd5, 1'b0, 1'b0)));
        write_entry(4'd12, make_hi(19'h00030, 8'h44, 1'b1), make_pair(
            make_lo(20'h0E000, 3'd1, 1'b1, 1'b1), make_lo(20'h0E001, 3'd1, 1'b1, 1'b1)));
        write_entry(4'd14, make_hi(19'h00030, 8'h44, 1'b0), make_pair(
            make_lo(20'h0F000, 3'd6, 1'b0, 1'b1), make_lo(20'h0F001, 3'd7, 1'b1, 1'b0)));

        lookup(make_req(20'h00020, 8'h11), make_req(20'h00021, 8'h11));
        lookup(make_req(20'h00041, 8'h99), make_req(20'h00040, 8'h00));    // Global entry
        lookup(make_req(20'hC0009, 8'h11), make_req(20'h00021, 8'h33));
        lookup(make_req(20'h00020, 8'h22), make_req(20'hC0008, 8'h12));    // ASID mismatch

        lookup(make_req(20'h80123, 8'h00), make_req(20'hA0456, 8'h00));
        lookup(make_req(20'hBFFFF, 8'h7E), make_req(20'h9ABCD, 8'h01));

        write_entry(4'd6, make_hi(19'h12345, 8'h5A, 1'b1), make_pair(
            make_lo(20'h54321, 3'd5, 1'b1, 1'b0), make_lo(20'hFEDCB, 3'd2, 1'b0, 1'b1)));
        read_entry(4'd6);
        kseg0_cache <= 3'd5;                          // New kseg0 attribute for the rest of the run
        read_entry(4'd3);

        lookup(make_req(20'h00061, 8'h44), make_req(20'h00060, 8'h44));    // Entries 12 and 14
        lookup(make_req(20'h00060, 8'h77), make_req(20'h00061, 8'h77));    // Only 12 is global

        for (int n = 0; n < 400; n++) begin
            r  = $random(seed);
            hi = make_hi({r[8] ? 3'b110 : 3'b001, 12'h000, r[3:0]}, {6'd0, r[5:4]}, r[6]);
            pp = make_pair(make_lo(r[31:12], r[11:9], r[7], r[6]),
                           make_lo(~r[31:12], r[2:0], r[5], r[3]));
            r  = $random(seed);
            case (r[2:0])
                3'd0, 3'd1: write_entry(r[7:4], hi, pp);
                3'd2:       read_entry(r[7:4]);
                default:    lookup(random_req(), random_req());
            endcase
        end

        lookup(make_req(20'h00000, 8'h55), make_req(20'h00000, 8'h55));
        finish_req = 1'b1;
        wait_count = 0;
        while (!compare_done && (wait_count < 10)) begin
            @(posedge clock);
            wait_count++;
        end
        if (!compare_done) begin
            $display("Timeout: the checker did not finish after the last request");
            $display("SIMULATION FAILED");
        end else begin
            $display("Checks: %0d, errors: %0d (translation %0d, tlbr %0d, probe %0d)",
                     check_count, trans_errors + read_errors + probe_errors,
                     trans_errors, read_errors, probe_errors);
            if ((trans_errors + read_errors + probe_errors) == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
        end
        $finish;
    end

    initial begin : watchdog
        for (int cyc = 0; cyc < 5000; cyc++) begin
            @(posedge clock);
        end
        $display("Timeout: the run did not finish within 5000 clock cycles");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tlb_16.f */
tlb_pkg.sv
tlb_tag_cam.sv
tlb_page_ram.sv
tlb_match_stage.sv
tlb_result_stage.sv
tlb_16.sv
tb_tlb_16.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the TLB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_tlb_16 -f tlb_16.f -o sim_tlb_16

out=$(./obj_dir/sim_tlb_16)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
